// File: tb/fetch_patterns.hex
// word 0 run length in cycles, words 1 to 8 the line image
// (the word at byte address a is image[a[4:2]] xor a)
// then redirect events as cycle and target pc, a zero pair ends the list
00000190
00000013
00100093
00208113
002081b3
40308233
0041a2b3
00529313
fe000ee3
00000040 aaaaa01c
000000a0 aaab0104
000000a3 00001ff8
00000120 aaaaa000
00000000 00000000

// File: sources.f
common/fetch_pkg.sv
common/line_fill_if.sv
fetch/fetch_unit.sv
rtl/line_fill.sv
rtl/instr_queue.sv
rtl/fetch_frontend.sv
tb/fetch_checker.sv
tb/tb_fetch_frontend.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --Wno-fatal -f sources.f \
    --top-module tb_fetch_frontend -o tb_fetch_frontend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_fetch_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0

// File: tb/tb_fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;
    import fetch_pkg::*;

    logic               clk;
    logic               rst;
    logic [ADDR_W-1:0]  bmem_addr_o;
    logic               bmem_read_o;
    logic               bmem_ready_i;
    logic [ADDR_W-1:0]  bmem_raddr_i;
    logic [BEAT_W-1:0]  bmem_rdata_i;
    logic               bmem_rvalid_i;
    logic               redirect_i;
    logic [ADDR_W-1:0]  redirect_pc_i;
    logic               instr_valid_o;
    logic               instr_ready_i;
    logic [ADDR_W-1:0]  instr_pc_o;
    logic [INSTR_W-1:0] instr_o;

    // word 0 run length, words 1 to 8 line image, then redirect events
    logic [31:0] pat [32];
    logic [15:0] lfsr;
    int          limit = 0;
    int          cycles = 0;
    int          err_count;
    int          deliver_count;
    int          fill_count;

    // image repeats every line, mixed with the full address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return pat[1 + int'(addr[4:2])] ^ addr;
    endfunction

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic int take_bits(input int n);
        int   val;
        int   i;
        logic fb;
        val = 0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = val * 2 + int'(fb);
        end
        return val;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    fetch_frontend u_dut (.*);

    fetch_checker u_chk (
        .clk             (clk),
        .rst             (rst),
        .bmem_addr_i     (bmem_addr_o),
        .bmem_read_i     (bmem_read_o),
        .bmem_raddr_i    (bmem_raddr_i),
        .bmem_rvalid_i   (bmem_rvalid_i),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .instr_valid_i   (instr_valid_o),
        .instr_ready_i   (instr_ready_i),
        .instr_pc_i      (instr_pc_o),
        .instr_i         (instr_o),
        .err_count_o     (err_count),
        .deliver_count_o (deliver_count),
        .fill_count_o    (fill_count)
    );

    // run limit derived from the pattern length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("sim failed");
            $finish;
        end
    end

    // burst memory, one read at a time
    initial begin
        logic [ADDR_W-1:0] base;
        int                gap;
        int                b;
        forever begin
            @(posedge clk);
            if (bmem_read_o) begin
                base = bmem_addr_o;
                gap  = take_bits(3);
                #1;
                bmem_ready_i = 1'b0;
                // stray beats for another line while waiting
                repeat (gap) begin
                    bmem_raddr_i  = base ^ 32'h40;
                    bmem_rdata_i  = {2{~base}};
                    bmem_rvalid_i = 1'b1;
                    @(posedge clk);
                    #1;
                end
                for (b = 0; b < BEATS_PER_LINE; b++) begin
                    bmem_raddr_i  = base;
                    bmem_rdata_i  = {mem_word(base + 32'(8 * b + 4)), mem_word(base + 32'(8 * b))};
                    bmem_rvalid_i = 1'b1;
                    @(posedge clk);
                    #1;
                end
                bmem_rvalid_i = 1'b0;
                bmem_ready_i  = 1'b1;
            end
        end
    end

    initial begin
        int cycle;
        int ev;
        int total;
        foreach (pat[i]) begin
            pat[i] = '0;
        end
        $readmemh("tb/fetch_patterns.hex", pat);
        lfsr          = 16'd88;
        limit         = 4 * int'(pat[0]);
        rst           = 1'b1;
        bmem_ready_i  = 1'b1;
        bmem_raddr_i  = '0;
        bmem_rdata_i  = '0;
        bmem_rvalid_i = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        instr_ready_i = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        ev  = 9;
        for (cycle = 1; cycle <= int'(pat[0]); cycle++) begin
            redirect_i = 1'b0;
            // zero cycle ends the event list
            if (pat[ev] != 0 && int'(pat[ev]) == cycle) begin
                redirect_i    = 1'b1;
                redirect_pc_i = pat[ev + 1];
                ev            = ev + 2;
            end
            // alternating slow and fast consumer phases
            instr_ready_i = cycle[6] ? (take_bits(2) == 0) : (take_bits(2) != 0);
            @(posedge clk);
            #1;
        end
        total = err_count;
        if (deliver_count == 0) begin
            $display("no instruction was delivered during the run");
            total = total + 1;
        end
        $display("errors: %0d, instructions delivered: %0d, line fills: %0d",
                 total, deliver_count, fill_count);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [fetch_pkg::ADDR_W-1:0]  bmem_addr_i,
    input  wire logic                          bmem_read_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0]  bmem_raddr_i,
    input  wire logic                          bmem_rvalid_i,
    input  wire logic                          redirect_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0]  redirect_pc_i,
    input  wire logic                          instr_valid_i,
    input  wire logic                          instr_ready_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0]  instr_pc_i,
    input  wire logic [fetch_pkg::INSTR_W-1:0] instr_i,
    output int                                 err_count_o,
    output int                                 deliver_count_o,
    output int                                 fill_count_o
);
    import fetch_pkg::*;

    logic [31:0]       pat [32];
    logic [ADDR_W-1:0] exp_pc;
    logic [ADDR_W-1:0] last_read;
    int                free_reads;
    int                beats_left;
    logic              held;

    initial begin
        err_count_o = 0;
        foreach (pat[i]) begin
            pat[i] = '0;
        end
        $readmemh("tb/fetch_patterns.hex", pat);
    end

    function automatic logic [31:0] expected_instr(input logic [31:0] addr);
        return pat[1 + int'(addr[4:2])] ^ addr;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            err_count_o++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        err_count_o++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            if (instr_valid_i || bmem_read_i) begin
                report_problem("instr_valid_o or bmem_read_o high during reset");
            end
            deliver_count_o = 0;
            fill_count_o    = 0;
            exp_pc          = RESET_PC;
            // first read must be the reset line
            last_read       = RESET_PC - 32'd32;
            free_reads      = 0;
            beats_left      = 0;
            held            = 1'b0;
        end else begin
            if (instr_valid_i && fill_count_o == 0) begin
                report_problem("instr_valid_o high before the first line fill");
            end
            if (held && !instr_valid_i) begin
                report_problem("instr_valid_o dropped without a transfer");
            end
            if (instr_valid_i && instr_ready_i) begin
                compare_value("instr_pc_o", instr_pc_i, exp_pc);
                compare_value("instr_o", instr_i, expected_instr(exp_pc));
                exp_pc = exp_pc + 32'd4;
                deliver_count_o++;
            end
            held = instr_valid_i && !instr_ready_i && !redirect_i;

            if (bmem_read_i) begin
                if (beats_left != 0) begin
                    report_problem("burst read issued while a fill is outstanding");
                end
                compare_value("bmem_addr_o[4:0]", {27'b0, bmem_addr_i[4:0]}, 32'd0);
                // reads around a redirect may jump
                if (free_reads > 0) begin
                    free_reads--;
                end else begin
                    compare_value("bmem_addr_o", bmem_addr_i, last_read + 32'd32);
                end
                last_read  = bmem_addr_i;
                beats_left = BEATS_PER_LINE;
            end else if (bmem_rvalid_i && bmem_raddr_i == last_read && beats_left > 0) begin
                beats_left--;
                if (beats_left == 0) begin
                    fill_count_o++;
                end
            end

            if (redirect_i) begin
                exp_pc     = redirect_pc_i;
                free_reads = 2;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
    input  wire logic                           clk,
    input  wire logic                           rst,

    output logic [fetch_pkg::ADDR_W-1:0]        bmem_addr_o,
    output logic                                bmem_read_o,
    input  wire logic                           bmem_ready_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0]   bmem_raddr_i,
    input  wire logic [fetch_pkg::BEAT_W-1:0]   bmem_rdata_i,
    input  wire logic                           bmem_rvalid_i,

    input  wire logic                           redirect_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0]   redirect_pc_i,

    output logic                                instr_valid_o,
    input  wire logic                           instr_ready_i,
    output logic [fetch_pkg::ADDR_W-1:0]        instr_pc_o,
    output logic [fetch_pkg::INSTR_W-1:0]       instr_o
);
    import fetch_pkg::*;

    line_fill_if fill_bus ();

    // fetch to queue
    logic               enq;
    logic [ADDR_W-1:0]  enq_pc;
    logic [INSTR_W-1:0] enq_instr;
    logic               queue_full;

    fetch_unit u_fetch (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .fill          (fill_bus.fetch),
        .enq_o         (enq),
        .enq_pc_o      (enq_pc),
        .enq_instr_o   (enq_instr),
        .full_i        (queue_full)
    );

    line_fill u_fill (
        .clk           (clk),
        .rst           (rst),
        .fill          (fill_bus.fill),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    // redirect also empties the queue
    instr_queue u_queue (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (redirect_i),
        .enq_i       (enq),
        .enq_pc_i    (enq_pc),
        .enq_instr_i (enq_instr),
        .full_o      (queue_full),
        .valid_o     (instr_valid_o),
        .ready_i     (instr_ready_i),
        .pc_o        (instr_pc_o),
        .instr_o     (instr_o)
    );

endmodule

`default_nettype wire

// File: rtl/instr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module instr_queue (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           flush_i,
    input  wire logic                           enq_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0]   enq_pc_i,
    input  wire logic [fetch_pkg::INSTR_W-1:0]  enq_instr_i,
    output logic                                full_o,
    output logic                                valid_o,
    input  wire logic                           ready_i,
    output logic [fetch_pkg::ADDR_W-1:0]        pc_o,
    output logic [fetch_pkg::INSTR_W-1:0]       instr_o
);
    import fetch_pkg::*;

    logic [ADDR_W-1:0]                pc_mem    [QUEUE_DEPTH];
    logic [INSTR_W-1:0]               instr_mem [QUEUE_DEPTH];
    logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(QUEUE_DEPTH+1)-1:0] count;
    logic                             do_enq;
    logic                             do_deq;

    assign full_o  = int'(count) == QUEUE_DEPTH;
    assign valid_o = count != '0;
    assign pc_o    = pc_mem[rd_ptr];
    assign instr_o = instr_mem[rd_ptr];

    assign do_enq = enq_i && !full_o;
    assign do_deq = valid_o && ready_i;

    // flush drops every entry in one cycle
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            pc_mem[wr_ptr]    <= enq_pc_i;
            instr_mem[wr_ptr] <= enq_instr_i;
        end
    end

    // producer must honour full
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        enq_i && !flush_i |-> !full_o);

endmodule

`default_nettype wire

// File: rtl/line_fill.sv
`timescale 1ns/1ps
`default_nettype none

module line_fill (
    input  wire logic                          clk,
    input  wire logic                          rst,
    line_fill_if.fill                          fill,
    output logic [fetch_pkg::ADDR_W-1:0]       bmem_addr_o,
    output logic                               bmem_read_o,
    input  wire logic                          bmem_ready_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0]  bmem_raddr_i,
    input  wire logic [fetch_pkg::BEAT_W-1:0]  bmem_rdata_i,
    input  wire logic                          bmem_rvalid_i
);
    import fetch_pkg::*;

    enum logic [1:0] {IDLE, ISSUE, COLLECT} state;

    logic [ADDR_W-1:0]                 addr_r;
    logic [LINE_W-1:0]                 line_r;
    logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt;
    logic                              resp_r;
    logic                              beat_ok;
    logic                              last_beat;

    // beats for another line are ignored
    assign beat_ok   = (state == COLLECT) && bmem_rvalid_i && (bmem_raddr_i == addr_r);
    assign last_beat = beat_ok && (int'(beat_cnt) == BEATS_PER_LINE - 1);

    // single read pulse, only while memory is ready
    assign bmem_read_o = (state == ISSUE) && bmem_ready_i;
    assign bmem_addr_o = addr_r;

    assign fill.line = line_r;
    assign fill.resp = resp_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            beat_cnt <= '0;
            resp_r   <= 1'b0;
        end else begin
            resp_r <= last_beat;
            case (state)
                IDLE: begin
                    // req is still high during the resp cycle
                    if (fill.req && !resp_r) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (bmem_ready_i) begin
                        state    <= COLLECT;
                        beat_cnt <= '0;
                    end
                end
                COLLECT: begin
                    if (beat_ok) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (last_beat) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // beats land lowest first
    always_ff @(posedge clk) begin
        if (state == IDLE && fill.req) begin
            addr_r <= fill.addr;
        end
        if (beat_ok) begin
            line_r[beat_cnt * BEAT_W +: BEAT_W] <= bmem_rdata_i;
        end
    end

    a_read_pulse: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |=> !bmem_read_o);

endmodule

`default_nettype wire

// File: fetch/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          redirect_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0]  redirect_pc_i,
    line_fill_if.fetch                         fill,
    output logic                               enq_o,
    output logic [fetch_pkg::ADDR_W-1:0]       enq_pc_o,
    output logic [fetch_pkg::INSTR_W-1:0]      enq_instr_o,
    input  wire logic                          full_i
);
    import fetch_pkg::*;

    logic [ADDR_W-1:0]               pc;
    logic [LINE_W-1:0]               line_buf;
    logic [ADDR_W-LINE_OFFSET_W-1:0] line_tag;
    logic                            line_valid;
    logic                            req_r;
    logic [ADDR_W-1:0]               req_addr;
    logic                            discard;

    logic                            hit;
    logic                            resp_use;
    logic                            miss;
    logic [WORD_SEL_W-1:0]           word_sel;
    logic [LINE_W-1:0]               line_src;

    assign hit = line_valid && (pc[ADDR_W-1:LINE_OFFSET_W] == line_tag);

    // returned line belongs to the current stream
    assign resp_use = fill.resp && !discard && !redirect_i;

    // new request goes out the cycle after this
    assign miss = !hit && !req_r && !redirect_i;

    // word served straight from the fill on resp, else from the buffer
    assign word_sel = pc[LINE_OFFSET_W-1 -: WORD_SEL_W];
    assign line_src = resp_use ? fill.line : line_buf;

    assign enq_o       = (hit || resp_use) && !full_i && !redirect_i;
    assign enq_pc_o    = pc;
    assign enq_instr_o = line_src[word_sel * (LINE_W / WORDS_PER_LINE) +: INSTR_W];

    assign fill.req  = req_r;
    assign fill.addr = req_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= RESET_PC;
            line_valid <= 1'b0;
            req_r      <= 1'b0;
            discard    <= 1'b0;
        end else begin
            // pc holds while the queue is full
            if (redirect_i) begin
                pc <= redirect_pc_i;
            end else if (enq_o) begin
                pc <= pc + ADDR_W'(INSTR_W / 8);
            end

            if (redirect_i) begin
                line_valid <= 1'b0;
            end else if (resp_use) begin
                line_valid <= 1'b1;
            end

            if (fill.resp) begin
                req_r <= 1'b0;
            end else if (miss) begin
                req_r <= 1'b1;
            end

            // fill in flight at redirect time completes but is dropped
            if (fill.resp) begin
                discard <= 1'b0;
            end else if (redirect_i && req_r) begin
                discard <= 1'b1;
            end
        end
    end

    // line buffer contents and request address
    always_ff @(posedge clk) begin
        if (resp_use) begin
            line_buf <= fill.line;
            line_tag <= req_addr[ADDR_W-1:LINE_OFFSET_W];
        end
        if (miss) begin
            req_addr <= {pc[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
        end
    end

    // a fill answers only an open request
    a_resp_with_req: assert property (@(posedge clk) disable iff (rst)
        fill.resp |-> fill.req);

    // open request keeps its address until the fill answers
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        fill.req && !fill.resp |=> fill.req && $stable(fill.addr));

endmodule

`default_nettype wire

// File: common/line_fill_if.sv
`timescale 1ns/1ps
`default_nettype none

interface line_fill_if;
    import fetch_pkg::*;

    // line request from fetch, held until resp
    logic              req;
    logic [ADDR_W-1:0] addr;

    // returned line, valid with the resp pulse
    logic [LINE_W-1:0] line;
    logic              resp;

    modport fetch (output req, output addr, input line, input resp);
    modport fill (input req, input addr, output line, output resp);

endinterface

`default_nettype wire

// File: common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // bus and word widths
    localparam int ADDR_W  = 32;
    localparam int INSTR_W = 32;
    localparam int BEAT_W  = 64;
    localparam int LINE_W  = 256;

    // line geometry
    localparam int BEATS_PER_LINE = LINE_W / BEAT_W;
    localparam int WORDS_PER_LINE = LINE_W / INSTR_W;
    localparam int LINE_OFFSET_W  = $clog2(LINE_W / 8);
    localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);

    // instruction queue entries
    localparam int QUEUE_DEPTH = 32;

    // first fetch address after reset
    localparam logic [ADDR_W-1:0] RESET_PC = 32'haaaa_a000;

endpackage

`default_nettype wire
